//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // Access width and signedness
  localparam logic [2:0] F3_B    = 3'b000;
  localparam logic [2:0] F3_H    = 3'b001;
  localparam logic [2:0] F3_W    = 3'b010;
  localparam logic [2:0] F3_BU   = 3'b100;
  localparam logic [2:0] F3_HU   = 3'b101;
  localparam logic [2:0] F3_ADDI = 3'b000;

  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

  typedef enum logic [3:0] {
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_LUI, OP_EBREAK, OP_ILLEGAL
  } op_e;

  typedef enum logic [1:0] {
    SZ_BYTE, SZ_HALF, SZ_WORD
  } size_e;

  typedef enum logic [1:0] {
    PH_FETCH, PH_EXEC, PH_HALT
  } phase_e;

endpackage

`default_nettype wire

//--- instr_decoder.sv
`default_nettype none

module instr_decoder import cpu_pkg::*; (
  input  wire [31:0]  i_ir,
  output op_e         o_op,
  output logic [4:0]  o_rd,
  output logic [4:0]  o_rs1,
  output logic [4:0]  o_rs2,
  output logic [31:0] o_imm
);

  logic [6:0]  w_opcode;
  logic [2:0]  w_funct3;
  logic [31:0] w_imm_i;
  logic [31:0] w_imm_s;
  logic [31:0] w_imm_u;

  assign w_opcode = i_ir[6:0];
  assign w_funct3 = i_ir[14:12];

  assign o_rd  = i_ir[11:7];
  assign o_rs1 = i_ir[19:15];
  assign o_rs2 = i_ir[24:20];

  assign w_imm_i = {{20{i_ir[31]}}, i_ir[31:20]};
  assign w_imm_s = {{20{i_ir[31]}}, i_ir[31:25], i_ir[11:7]};
  assign w_imm_u = {i_ir[31:12], 12'h000};

  always_comb begin
    o_op  = OP_ILLEGAL;
    o_imm = w_imm_i;  // Loads and ADDI
    case (w_opcode)
      OPC_LOAD: begin
        case (w_funct3)
          F3_B:    o_op = OP_LB;
          F3_H:    o_op = OP_LH;
          F3_W:    o_op = OP_LW;
          F3_BU:   o_op = OP_LBU;
          F3_HU:   o_op = OP_LHU;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        o_imm = w_imm_s;
        case (w_funct3)
          F3_B:    o_op = OP_SB;
          F3_H:    o_op = OP_SH;
          F3_W:    o_op = OP_SW;
          default: o_op = OP_ILLEGAL;
        endcase
      end
      OPC_OP_IMM: begin
        if (w_funct3 == F3_ADDI) begin
          o_op = OP_ADDI;
        end
      end
      OPC_LUI: begin
        o_op  = OP_LUI;
        o_imm = w_imm_u;
      end
      OPC_SYSTEM: begin
        if (i_ir == INSTR_EBREAK) begin
          o_op = OP_EBREAK;
        end
      end
      default: o_op = OP_ILLEGAL;  // Halts the core
    endcase
  end

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  wire             i_clk,
  input  wire             i_arst_n,
  input  wire [4:0]       i_rs1_idx,
  input  wire [4:0]       i_rs2_idx,
  input  wire [4:0]       i_rd_idx,
  input  wire             i_we,
  input  wire [XLEN-1:0]  i_wdata,
  output logic [XLEN-1:0] o_rs1_val,
  output logic [XLEN-1:0] o_rs2_val
);

  logic [XLEN-1:0] r_regs [32];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 32; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_we && (i_rd_idx != 5'd0)) begin  // x0 never written
      r_regs[i_rd_idx] <= i_wdata;
    end
  end

  // Asynchronous read ports
  assign o_rs1_val = r_regs[i_rs1_idx];
  assign o_rs2_val = r_regs[i_rs2_idx];

endmodule

`default_nettype wire

//--- load_store.sv
`default_nettype none

module load_store import cpu_pkg::*; (
  input  wire             i_clk,
  input  wire             i_arst_n,
  input  wire phase_e     i_phase,
  input  wire op_e        i_op,
  input  wire [XLEN-1:0]  i_rs1_val,
  input  wire [XLEN-1:0]  i_rs2_val,
  input  wire [XLEN-1:0]  i_imm,
  input  wire [XLEN-1:0]  i_pc,
  input  wire             i_start_fetch,
  input  wire             i_bus_done,
  input  wire [XLEN-1:0]  i_bus_rdata,
  output logic            o_bus_req,
  output logic            o_bus_we,
  output size_e           o_bus_size,
  output logic [XLEN-1:0] o_bus_addr,
  output logic [XLEN-1:0] o_bus_wdata,
  output logic [XLEN-1:0] o_load_value,
  output logic            o_load_valid,
  output logic [XLEN-1:0] o_ir_value,
  output logic            o_ir_valid,
  output logic            o_ls_done
);

  typedef enum logic {
    LS_READY,
    LS_WAITING
  } ls_state_e;

  ls_state_e       r_state;
  logic            r_first_fetch;  // Fetch at PC after reset without a start pulse
  logic            r_data_issued;  // Data access already sent for this instruction
  logic            w_is_load;
  logic            w_is_store;
  size_e           w_data_size;
  logic [XLEN-1:0] w_store_data;
  logic [XLEN-1:0] w_load_ext;
  logic            w_fetch_go;
  logic            w_data_go;
  logic            w_done;

  always_comb begin
    w_is_load    = 1'b0;
    w_is_store   = 1'b0;
    w_data_size  = SZ_WORD;
    w_store_data = i_rs2_val;
    w_load_ext   = i_bus_rdata;
    case (i_op)
      OP_LB: begin
        w_is_load   = 1'b1;
        w_data_size = SZ_BYTE;
        w_load_ext  = {{24{i_bus_rdata[7]}}, i_bus_rdata[7:0]};
      end
      OP_LBU: begin
        w_is_load   = 1'b1;
        w_data_size = SZ_BYTE;
        w_load_ext  = {24'h00_0000, i_bus_rdata[7:0]};
      end
      OP_LH: begin
        w_is_load   = 1'b1;
        w_data_size = SZ_HALF;
        w_load_ext  = {{16{i_bus_rdata[15]}}, i_bus_rdata[15:0]};
      end
      OP_LHU: begin
        w_is_load   = 1'b1;
        w_data_size = SZ_HALF;
        w_load_ext  = {16'h0000, i_bus_rdata[15:0]};
      end
      OP_LW:  w_is_load = 1'b1;
      OP_SB: begin
        w_is_store   = 1'b1;
        w_data_size  = SZ_BYTE;
        w_store_data = {24'h00_0000, i_rs2_val[7:0]};
      end
      OP_SH: begin
        w_is_store   = 1'b1;
        w_data_size  = SZ_HALF;
        w_store_data = {16'h0000, i_rs2_val[15:0]};
      end
      OP_SW:  w_is_store = 1'b1;
      default: ;
    endcase
  end

  assign w_fetch_go = (i_phase == PH_FETCH) && (r_state == LS_READY) &&
                      (i_start_fetch || r_first_fetch);
  assign w_data_go  = (i_phase == PH_EXEC) && (r_state == LS_READY) && !r_data_issued &&
                      (w_is_load || w_is_store);
  assign w_done     = (r_state == LS_WAITING) && i_bus_done;

  // Store completes in the cycle the bus answers
  assign o_ls_done = (i_phase == PH_EXEC) && w_is_store && w_done;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_state       <= LS_READY;
      r_first_fetch <= 1'b1;
      r_data_issued <= 1'b0;
      o_bus_req     <= 1'b0;
      o_bus_we      <= 1'b0;
      o_ir_valid    <= 1'b0;
      o_load_valid  <= 1'b0;
    end else begin
      o_bus_req    <= 1'b0;
      o_ir_valid   <= 1'b0;
      o_load_valid <= 1'b0;
      if (i_phase != PH_EXEC) begin
        r_data_issued <= 1'b0;
      end
      if (w_fetch_go) begin
        r_first_fetch <= 1'b0;
        o_bus_req     <= 1'b1;
        o_bus_we      <= 1'b0;
        r_state       <= LS_WAITING;
      end else if (w_data_go) begin
        r_data_issued <= 1'b1;
        o_bus_req     <= 1'b1;
        o_bus_we      <= w_is_store;
        r_state       <= LS_WAITING;
      end else if (w_done) begin
        r_state <= LS_READY;
        if (i_phase == PH_FETCH) begin
          o_ir_valid <= 1'b1;
        end else if (w_is_load) begin
          o_load_valid <= 1'b1;
        end
      end
    end
  end

  // Request payload, held until done
  always_ff @(posedge i_clk) begin
    if (w_fetch_go) begin
      o_bus_size  <= SZ_WORD;
      o_bus_addr  <= i_pc;
      o_bus_wdata <= '0;
    end else if (w_data_go) begin
      o_bus_size  <= w_data_size;
      o_bus_addr  <= i_rs1_val + i_imm;
      o_bus_wdata <= w_store_data;
    end
    if (w_done) begin
      if (i_phase == PH_FETCH) begin
        o_ir_value <= i_bus_rdata;
      end else begin
        o_load_value <= w_load_ext;
      end
    end
  end

endmodule

`default_nettype wire

//--- wb_master.sv
`default_nettype none

module wb_master import cpu_pkg::*; (
  input  wire             i_clk,
  input  wire             i_arst_n,
  input  wire             i_req,
  input  wire             i_we,
  input  wire size_e      i_size,
  input  wire [XLEN-1:0]  i_addr,
  input  wire [XLEN-1:0]  i_wdata,
  input  wire [XLEN-1:0]  i_wb_dat,
  input  wire             i_wb_ack,
  output logic            o_done,
  output logic [XLEN-1:0] o_rdata,
  output logic            o_wb_cyc,
  output logic            o_wb_stb,
  output logic            o_wb_we,
  output logic [XLEN-1:0] o_wb_adr,
  output logic [3:0]      o_wb_sel,
  output logic [XLEN-1:0] o_wb_dat
);

  typedef enum logic {
    WB_IDLE,
    WB_BUSY
  } wb_state_e;

  wb_state_e       r_state;
  logic [1:0]      r_lane;  // Byte offset of the current access
  logic [3:0]      w_sel;
  logic [XLEN-1:0] w_wdat;
  logic            w_start;
  logic            w_ack;

  assign w_start = (r_state == WB_IDLE) && i_req;
  assign w_ack   = (r_state == WB_BUSY) && i_wb_ack;

  always_comb begin
    case (i_size)
      SZ_BYTE: w_sel = 4'b0001 << i_addr[1:0];
      SZ_HALF: w_sel = 4'b0011 << i_addr[1:0];
      default: w_sel = 4'b1111;
    endcase
  end

  assign w_wdat = i_wdata << {i_addr[1:0], 3'b000};  // Move store data onto its lanes

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_state  <= WB_IDLE;
      o_wb_cyc <= 1'b0;
      o_wb_stb <= 1'b0;
      o_wb_we  <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (w_start) begin
        o_wb_cyc <= 1'b1;
        o_wb_stb <= 1'b1;
        o_wb_we  <= i_we;
        r_state  <= WB_BUSY;
      end else if (w_ack) begin
        o_wb_cyc <= 1'b0;  // Cycle ends the cycle after ack
        o_wb_stb <= 1'b0;
        o_wb_we  <= 1'b0;
        o_done   <= 1'b1;
        r_state  <= WB_IDLE;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_start) begin
      o_wb_adr <= {i_addr[XLEN-1:2], 2'b00};
      o_wb_sel <= w_sel;
      o_wb_dat <= w_wdat;
      r_lane   <= i_addr[1:0];
    end
    if (w_ack) begin
      o_rdata <= i_wb_dat >> {r_lane, 3'b000};  // Read data down to bit 0
    end
  end

endmodule

`default_nettype wire

//--- core_control.sv
`default_nettype none

module core_control import cpu_pkg::*; (
  input  wire             i_clk,
  input  wire             i_arst_n,
  input  wire op_e        i_op,
  input  wire [XLEN-1:0]  i_imm,
  input  wire [XLEN-1:0]  i_rs1_val,
  input  wire [XLEN-1:0]  i_ir_value,
  input  wire             i_ir_valid,
  input  wire             i_load_valid,
  input  wire [XLEN-1:0]  i_load_value,
  input  wire             i_ls_done,
  output phase_e          o_phase,
  output logic [XLEN-1:0] o_pc,
  output logic [XLEN-1:0] o_ir,
  output logic            o_start_fetch,
  output logic            o_rd_we,
  output logic [XLEN-1:0] o_rd_wdata,
  output logic            o_halted
);

  logic w_is_alu;
  logic w_is_load;
  logic w_is_store;
  logic w_is_halt;
  logic w_retire;  // Instruction finishes this cycle

  assign w_is_alu   = (i_op == OP_ADDI) || (i_op == OP_LUI);
  assign w_is_load  = (i_op == OP_LB) || (i_op == OP_LH) || (i_op == OP_LW) ||
                      (i_op == OP_LBU) || (i_op == OP_LHU);
  assign w_is_store = (i_op == OP_SB) || (i_op == OP_SH) || (i_op == OP_SW);
  assign w_is_halt  = (i_op == OP_EBREAK) || (i_op == OP_ILLEGAL);

  assign w_retire = (o_phase == PH_EXEC) &&
                    (w_is_alu || (w_is_load && i_load_valid) || (w_is_store && i_ls_done));
  assign o_rd_we  = (o_phase == PH_EXEC) && (w_is_alu || (w_is_load && i_load_valid));
  assign o_halted = (o_phase == PH_HALT);

  always_comb begin
    case (i_op)
      OP_ADDI: o_rd_wdata = i_rs1_val + i_imm;
      OP_LUI:  o_rd_wdata = i_imm;  // Already shifted by the decoder
      default: o_rd_wdata = i_load_value;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_phase       <= PH_FETCH;
      o_pc          <= RESET_PC;
      o_start_fetch <= 1'b0;
    end else begin
      o_start_fetch <= 1'b0;
      case (o_phase)
        PH_FETCH: begin
          if (i_ir_valid) begin
            o_phase <= PH_EXEC;
          end
        end
        PH_EXEC: begin
          if (w_is_halt) begin
            o_phase <= PH_HALT;
          end else if (w_retire) begin
            o_phase       <= PH_FETCH;
            o_pc          <= o_pc + 32'd4;
            o_start_fetch <= 1'b1;
          end
        end
        default: ;  // Stays halted until reset
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((o_phase == PH_FETCH) && i_ir_valid) begin
      o_ir <= i_ir_value;
    end
  end

endmodule

`default_nettype wire

//--- ls_core_top.sv
`default_nettype none

module ls_core_top import cpu_pkg::*; (
  input  wire             i_clk,
  input  wire             i_arst_n,
  output logic            o_wb_cyc,
  output logic            o_wb_stb,
  output logic            o_wb_we,
  output logic [XLEN-1:0] o_wb_adr,
  output logic [3:0]      o_wb_sel,
  output logic [XLEN-1:0] o_wb_dat,
  input  wire [XLEN-1:0]  i_wb_dat,
  input  wire             i_wb_ack,
  output logic            o_halted
);

  phase_e          w_phase;
  op_e             w_op;
  size_e           w_bus_size;
  logic [XLEN-1:0] w_pc;
  logic [XLEN-1:0] w_ir;
  logic [XLEN-1:0] w_imm;
  logic [4:0]      w_rd;
  logic [4:0]      w_rs1;
  logic [4:0]      w_rs2;
  logic [XLEN-1:0] w_rs1_val;
  logic [XLEN-1:0] w_rs2_val;
  logic            w_rd_we;
  logic [XLEN-1:0] w_rd_wdata;
  logic            w_start_fetch;
  logic            w_bus_req;
  logic            w_bus_we;
  logic [XLEN-1:0] w_bus_addr;
  logic [XLEN-1:0] w_bus_wdata;
  logic            w_bus_done;
  logic [XLEN-1:0] w_bus_rdata;
  logic [XLEN-1:0] w_load_value;
  logic            w_load_valid;
  logic [XLEN-1:0] w_ir_value;
  logic            w_ir_valid;
  logic            w_ls_done;

  instr_decoder u_decoder (
    .i_ir (w_ir), .o_op (w_op), .o_rd (w_rd), .o_rs1 (w_rs1), .o_rs2 (w_rs2), .o_imm (w_imm)
  );

  reg_file u_regs (
    .i_clk     (i_clk),      .i_arst_n  (i_arst_n),
    .i_rs1_idx (w_rs1),      .i_rs2_idx (w_rs2),     .i_rd_idx (w_rd),
    .i_we      (w_rd_we),    .i_wdata   (w_rd_wdata),
    .o_rs1_val (w_rs1_val),  .o_rs2_val (w_rs2_val)
  );

  load_store u_lsu (
    .i_clk        (i_clk),        .i_arst_n     (i_arst_n),
    .i_phase      (w_phase),      .i_op         (w_op),
    .i_rs1_val    (w_rs1_val),    .i_rs2_val    (w_rs2_val),
    .i_imm        (w_imm),        .i_pc         (w_pc),
    .i_start_fetch(w_start_fetch),
    .i_bus_done   (w_bus_done),   .i_bus_rdata  (w_bus_rdata),
    .o_bus_req    (w_bus_req),    .o_bus_we     (w_bus_we),
    .o_bus_size   (w_bus_size),   .o_bus_addr   (w_bus_addr),
    .o_bus_wdata  (w_bus_wdata),
    .o_load_value (w_load_value), .o_load_valid (w_load_valid),
    .o_ir_value   (w_ir_value),   .o_ir_valid   (w_ir_valid),
    .o_ls_done    (w_ls_done)
  );

  wb_master u_wb (
    .i_clk    (i_clk),       .i_arst_n (i_arst_n),
    .i_req    (w_bus_req),   .i_we     (w_bus_we),    .i_size  (w_bus_size),
    .i_addr   (w_bus_addr),  .i_wdata  (w_bus_wdata),
    .i_wb_dat (i_wb_dat),    .i_wb_ack (i_wb_ack),
    .o_done   (w_bus_done),  .o_rdata  (w_bus_rdata),
    .o_wb_cyc (o_wb_cyc),    .o_wb_stb (o_wb_stb),    .o_wb_we (o_wb_we),
    .o_wb_adr (o_wb_adr),    .o_wb_sel (o_wb_sel),    .o_wb_dat (o_wb_dat)
  );

  core_control u_ctrl (
    .i_clk        (i_clk),        .i_arst_n     (i_arst_n),
    .i_op         (w_op),         .i_imm        (w_imm),
    .i_rs1_val    (w_rs1_val),
    .i_ir_value   (w_ir_value),   .i_ir_valid   (w_ir_valid),
    .i_load_valid (w_load_valid), .i_load_value (w_load_value),
    .i_ls_done    (w_ls_done),
    .o_phase      (w_phase),      .o_pc         (w_pc),
    .o_ir         (w_ir),         .o_start_fetch(w_start_fetch),
    .o_rd_we      (w_rd_we),      .o_rd_wdata   (w_rd_wdata),
    .o_halted     (o_halted)
  );

endmodule

`default_nettype wire

//--- ls_core_properties.sv
`default_nettype none

module ls_core_properties import cpu_pkg::*; (
  input wire            i_clk,
  input wire            i_arst_n,
  input wire            i_wb_cyc,
  input wire            i_wb_stb,
  input wire            i_wb_we,
  input wire [XLEN-1:0] i_wb_adr,
  input wire [3:0]      i_wb_sel,
  input wire [XLEN-1:0] i_wb_dat,
  input wire            i_wb_ack,
  input wire            i_halted
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // Watched by the testbench

  cyc_equals_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wb_cyc == i_wb_stb)
  else begin
    fail_cnt++;
    $error("o_wb_cyc = %h and o_wb_stb = %h differ", i_wb_cyc, i_wb_stb);
  end

  // Request fields hold while the slave inserts wait states
  held_until_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr) && $stable(i_wb_sel) &&
                                 $stable(i_wb_we) && $stable(i_wb_dat)))
  else begin
    fail_cnt++;
    $error("bus cycle dropped or changed before ack");
  end

  ends_after_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_wb_stb && i_wb_ack) |=> !i_wb_cyc)
  else begin
    fail_cnt++;
    $error("o_wb_cyc still high in the cycle after ack");
  end

  idle_when_halted: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_halted |-> (!i_wb_cyc ##1 i_halted))
  else begin
    fail_cnt++;
    $error("bus cycle while halted, or halt flag dropped");
  end

endmodule

`default_nettype wire

//--- tb_ls_core.sv
`default_nettype none

module tb_ls_core import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED      = 32'hfcca_ab64;
  localparam int          MEM_WORDS = 256;
  localparam int          N_OPS     = 32;
  localparam logic [31:0] DATA_BASE = 32'h0000_0300;  // x1, middle of the data half
  localparam logic [2:0]  STORE_F3 [3] = '{F3_B, F3_H, F3_W};
  localparam logic [2:0]  LOAD_F3 [5]  = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
  localparam int          LOAD_BYTES [5] = '{1, 2, 4, 1, 2};

  typedef struct packed {
    logic        we;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } bus_acc_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_out;
  logic [31:0] wb_dat_in;
  logic        wb_ack;
  logic        halted;
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] exp_mem [MEM_WORDS];
  logic [31:0] exp_regs [32];
  bus_acc_t    exp_q [$];  // Every bus access in program order
  logic [31:0] pc;
  int          n_instr;
  int          n_writes;
  int          n_writes_exp;
  int          wait_left;
  int          cycles;
  int          cycle_limit = 100_000;

  ls_core_top i_ls_core_top (
    .i_clk    (clk),        .i_arst_n (arst_n),
    .o_wb_cyc (wb_cyc),     .o_wb_stb (wb_stb),    .o_wb_we (wb_we),
    .o_wb_adr (wb_adr),     .o_wb_sel (wb_sel),    .o_wb_dat (wb_dat_out),
    .i_wb_dat (wb_dat_in),  .i_wb_ack (wb_ack),    .o_halted (halted)
  );

  bind ls_core_top ls_core_properties u_props (
    .i_clk    (i_clk),    .i_arst_n (i_arst_n),
    .i_wb_cyc (o_wb_cyc), .i_wb_stb (o_wb_stb), .i_wb_we  (o_wb_we),
    .i_wb_adr (o_wb_adr), .i_wb_sel (o_wb_sel), .i_wb_dat (o_wb_dat),
    .i_wb_ack (i_wb_ack), .i_halted (o_halted)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [3:0] lane_select(int nbytes, logic [1:0] lane);
    return (nbytes == 4) ? 4'hf : (nbytes == 2) ? (4'b0011 << lane) : (4'b0001 << lane);
  endfunction

  function automatic logic [31:0] lane_mask(logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  // Offset from x1 into the data half, aligned to the access width
  function automatic logic [11:0] random_offset(int nbytes);
    int lane;
    lane = (nbytes == 1) ? $urandom_range(0, 3) : (nbytes == 2) ? 2 * $urandom_range(0, 1) : 0;
    return 12'($urandom_range(0, 127) * 4 - 256 + lane);
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic emit(logic [31:0] instr);
    mem[pc[9:2]]     = instr;
    exp_mem[pc[9:2]] = instr;
    exp_q.push_back(bus_acc_t'{1'b0, pc, 4'hf, 32'h0});  // Its fetch
    pc += 4;
    n_instr++;
  endtask

  task automatic expect_store(logic [11:0] off, logic [31:0] val, int nbytes);
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [31:0] dat;
    addr = exp_regs[1] + {{20{off[11]}}, off};
    sel  = lane_select(nbytes, addr[1:0]);
    dat  = (val << (8 * addr[1:0])) & lane_mask(sel);
    exp_mem[addr[9:2]] = (exp_mem[addr[9:2]] & ~lane_mask(sel)) | dat;
    exp_q.push_back(bus_acc_t'{1'b1, {addr[31:2], 2'b00}, sel, dat});
    n_writes_exp++;
  endtask

  task automatic build_program();
    int          kind;
    int          k;
    int          nbytes;
    logic [11:0] off;
    logic [19:0] hi;
    logic [11:0] lo;
    logic [31:0] addr;
    logic [31:0] word;
    pc = RESET_PC;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = $urandom;
    end
    exp_mem = mem;
    exp_regs[1] = DATA_BASE;
    emit(enc_i(DATA_BASE[11:0], 5'd0, F3_ADDI, 5'd1, OPC_OP_IMM));
    for (int n = 0; n < N_OPS; n++) begin
      kind = (n < 8) ? n : $urandom_range(0, 7);  // First eight cover every width once
      if (kind < 3) begin  // Build a value in x2, then SB, SH or SW
        hi     = 20'($urandom);
        lo     = 12'($urandom);
        nbytes = 1 << kind;
        emit({hi, 5'd2, OPC_LUI});
        emit(enc_i(lo, 5'd2, F3_ADDI, 5'd2, OPC_OP_IMM));
        exp_regs[2] = {hi, 12'h000} + {{20{lo[11]}}, lo};
        off = random_offset(nbytes);
        emit(enc_s(off, 5'd2, 5'd1, STORE_F3[kind]));
        expect_store(off, exp_regs[2], nbytes);
      end else begin  // Load into x5, then SW x5 back
        k      = kind - 3;
        nbytes = LOAD_BYTES[k];
        off    = random_offset(nbytes);
        addr   = exp_regs[1] + {{20{off[11]}}, off};
        emit(enc_i(off, 5'd1, LOAD_F3[k], 5'd5, OPC_LOAD));
        exp_q.push_back(bus_acc_t'{1'b0, {addr[31:2], 2'b00},
                                   lane_select(nbytes, addr[1:0]), 32'h0});
        word = exp_mem[addr[9:2]] >> (8 * addr[1:0]);
        if (nbytes == 1) begin
          exp_regs[5] = (k < 3) ? {{24{word[7]}}, word[7:0]} : {24'h00_0000, word[7:0]};
        end else if (nbytes == 2) begin
          exp_regs[5] = (k < 3) ? {{16{word[15]}}, word[15:0]} : {16'h0000, word[15:0]};
        end else begin
          exp_regs[5] = word;
        end
        off = random_offset(4);
        emit(enc_s(off, 5'd5, 5'd1, F3_W));
        expect_store(off, exp_regs[5], 4);
      end
    end
    emit(INSTR_EBREAK);
    cycle_limit = n_instr * 16 + 100;
  endtask

  task automatic serve_access();
    bus_acc_t    acc;
    logic [31:0] m;
    if (exp_q.size() == 0) begin
      stop_on_error("bus access after the program should have halted");
    end
    acc = exp_q.pop_front();
    m   = lane_mask(acc.sel);
    assert (wb_we == acc.we)
      else stop_on_error($sformatf("error: o_wb_we = %h, expected %h", wb_we, acc.we));
    assert (wb_adr == acc.adr)
      else stop_on_error($sformatf("error: o_wb_adr = %h, expected %h", wb_adr, acc.adr));
    assert (wb_sel == acc.sel)
      else stop_on_error($sformatf("error: o_wb_sel = %h, expected %h", wb_sel, acc.sel));
    if (acc.we) begin
      assert ((wb_dat_out & m) == acc.dat)
        else stop_on_error($sformatf("error: o_wb_dat = %h, expected %h",
                                     wb_dat_out & m, acc.dat));
      mem[wb_adr[9:2]] = (mem[wb_adr[9:2]] & ~m) | (wb_dat_out & m);
      n_writes++;
    end else begin
      wb_dat_in = mem[wb_adr[9:2]];
    end
  endtask

  // Slave with 0 to 3 wait states per access
  always @(posedge clk) begin
    #1;
    if (!arst_n) begin
      wb_ack = 1'b0;
    end else if (wb_ack) begin
      wb_ack    = 1'b0;
      wait_left = $urandom_range(0, 3);
    end else if (wb_cyc && wb_stb) begin
      if (wait_left == 0) begin
        serve_access();
        wb_ack = 1'b1;
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    cycles++;
    assert (i_ls_core_top.u_props.fail_cnt == 0)
      else stop_on_error("a Wishbone protocol assertion failed");
    if (cycles > cycle_limit) begin
      stop_on_error("timeout, the core did not halt in time");
    end
  end

  initial begin
    void'($urandom(SEED));
    arst_n    = 1'b0;
    wb_ack    = 1'b0;
    wb_dat_in = '0;
    wait_left = $urandom_range(0, 3);
    build_program();
    repeat (4) @(posedge clk);
    #1;
    assert (!wb_cyc && !wb_stb && !wb_we && !halted)
      else stop_on_error("bus or halt flag active during reset");
    arst_n = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
    repeat (4) @(posedge clk);
    #1;
    assert (exp_q.size() == 0)
      else stop_on_error("core halted before all expected bus accesses");
    assert (n_writes == n_writes_exp)
      else stop_on_error($sformatf("error: write count = %h, expected %h",
                                   n_writes, n_writes_exp));
    for (int i = 0; i < MEM_WORDS; i++) begin
      assert (mem[i] == exp_mem[i])
        else stop_on_error($sformatf("error: mem[%h] = %h, expected %h", i, mem[i], exp_mem[i]));
    end
    if (i_ls_core_top.u_props.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_on_error("a Wishbone protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- files.f
cpu_pkg.sv
instr_decoder.sv
reg_file.sv
load_store.sv
wb_master.sv
core_control.sv
ls_core_top.sv
ls_core_properties.sv
tb_ls_core.sv
